// ==== list.f ====
+incdir+rtl
rtl/cuPkg.sv
rtl/mainDecoder.sv
rtl/aluDecoder.sv
rtl/fetchLink.sv
rtl/execRegister.sv
rtl/branchUnit.sv
rtl/controlUnit.sv
testbench/controlUnitTb.sv

// ==== rtl/aluDecoder.sv ====
/*
 ALU decoder. Picks the ALU operation from the instruction class and the
 function field; memory and jump classes compute an address with add.
*/
`include "cuDefs_defs.svh"

module aluDecoder (
    input  cuPkg::instrClassE     instrClass,
    input  logic [`CU_FUNC_W-1:0] func,
    output cuPkg::aluCtrlE        aluCtrl
);

    cuPkg::aluCtrlE funcOp;

    assign funcOp = cuPkg::aluCtrlE'(func);

    always_comb begin
        case (instrClass)
            cuPkg::clsScalarAlu,
            cuPkg::clsVectorAlu: begin
                aluCtrl = funcOp;
            end
            cuPkg::clsScalarImm: begin
                // no immediate subtract, falls back to add
                if (funcOp == cuPkg::aluSub) begin
                    aluCtrl = cuPkg::aluAdd;
                end else begin
                    aluCtrl = funcOp;
                end
            end
            cuPkg::clsBranchCond: begin
                aluCtrl = cuPkg::aluSub;    // flags for beq / bgt
            end
            default: begin
                aluCtrl = cuPkg::aluAdd;    // address calc or nothing
            end
        endcase
    end

endmodule

// ==== rtl/branchUnit.sv ====
/*
 Resolves the branch in execute from the ALU flags of the compare and
 drives the PC-source select, which also flushes the next instruction.
*/
module branchUnit (
    input  logic              exValid,
    input  cuPkg::branchKindE exBranchKind,
    input  logic              zero,
    input  logic              negative,
    input  logic              overflow,
    output logic              pcSrc
);

    logic taken;

    always_comb begin
        case (exBranchKind)
            cuPkg::brAlways: taken = 1'b1;
            cuPkg::brEq:     taken = zero;
            cuPkg::brGt:     taken = !zero && (negative == overflow);  // signed a > b
            default:         taken = 1'b0;
        endcase
    end

    assign pcSrc = exValid && taken;

endmodule

// ==== rtl/controlUnit.sv ====
/*
 Top of the decode-side control unit. Wires the fetch link, both decoders,
 the execute control register and the branch unit together.
*/
`include "cuDefs_defs.svh"

module controlUnit (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   instrReq,
    input  logic                   stall,
    input  logic                   zero,
    input  logic                   negative,
    input  logic                   overflow,
    input  logic [`CU_INSTR_W-1:0] instr,
    output logic                   instrAck,
    output logic                   exValid,
    output logic                   exRegW,
    output logic                   exRegWV,
    output logic                   exMemtoReg,
    output logic                   exMemW,
    output logic                   exMemSrc,
    output logic                   exAluSrc,
    output logic                   exIllegal,
    output logic [1:0]             exImmSrc,
    output logic [1:0]             exRegSrc,
    output cuPkg::aluCtrlE         exAluCtrl,
    output cuPkg::branchKindE      exBranchKind,
    output logic                   pcSrc
);

    logic              capture;
    logic              regW;
    logic              regWV;
    logic              memtoReg;
    logic              memW;
    logic              memSrc;
    logic              aluSrc;
    logic              aluOp;
    logic              illegal;
    logic [1:0]        immSrc;
    logic [1:0]        regSrc;
    cuPkg::branchKindE branchKind;
    cuPkg::instrClassE instrClass;
    cuPkg::aluCtrlE    aluCtrl;

    fetchLink u_fetchLink (
        .clk      (clk),
        .arstN    (arstN),
        .instrReq (instrReq),
        .stall    (stall),
        .instrAck (instrAck),
        .capture  (capture)
    );

    mainDecoder u_mainDecoder (
        .instr      (instr),
        .regW       (regW),
        .regWV      (regWV),
        .memtoReg   (memtoReg),
        .memW       (memW),
        .memSrc     (memSrc),
        .aluSrc     (aluSrc),
        .aluOp      (aluOp),
        .illegal    (illegal),
        .immSrc     (immSrc),
        .regSrc     (regSrc),
        .branchKind (branchKind),
        .instrClass (instrClass)
    );

    aluDecoder u_aluDecoder (
        .instrClass (instrClass),
        .func       (instr[`CU_FUNC_W-1:0]),
        .aluCtrl    (aluCtrl)
    );

    execRegister u_execRegister (
        .clk          (clk),
        .arstN        (arstN),
        .capture      (capture),
        .stall        (stall),
        .pcSrc        (pcSrc),
        .regW         (regW),
        .regWV        (regWV),
        .memtoReg     (memtoReg),
        .memW         (memW),
        .memSrc       (memSrc),
        .aluSrc       (aluSrc),
        .aluOp        (aluOp),
        .illegal      (illegal),
        .immSrc       (immSrc),
        .regSrc       (regSrc),
        .branchKind   (branchKind),
        .aluCtrl      (aluCtrl),
        .exValid      (exValid),
        .exRegW       (exRegW),
        .exRegWV      (exRegWV),
        .exMemtoReg   (exMemtoReg),
        .exMemW       (exMemW),
        .exMemSrc     (exMemSrc),
        .exAluSrc     (exAluSrc),
        .exIllegal    (exIllegal),
        .exImmSrc     (exImmSrc),
        .exRegSrc     (exRegSrc),
        .exAluCtrl    (exAluCtrl),
        .exBranchKind (exBranchKind)
    );

    branchUnit u_branchUnit (
        .exValid      (exValid),
        .exBranchKind (exBranchKind),
        .zero         (zero),
        .negative     (negative),
        .overflow     (overflow),
        .pcSrc        (pcSrc)
    );

endmodule

// ==== rtl/cuDefs_defs.svh ====
/*
 Field layout of the instruction word seen by the decode-side control unit.
 Include this wherever an opcode or function field is sliced out of instr.
*/
`ifndef CU_DEFS_SVH
`define CU_DEFS_SVH

// full instruction word
`define CU_INSTR_W 32

// opcode field, top six bits
`define CU_OPC_HI 31
`define CU_OPC_LO 26

// function field, sits at the bottom of the word
`define CU_FUNC_W 3

`endif

// ==== rtl/cuPkg.sv ====
/*
 Shared types of the control unit: instruction classes, ALU operations,
 branch kinds and the fetch handshake states. Referenced by scoped name.
*/
package cuPkg;

    typedef enum logic [3:0] {
        clsScalarAlu,   // opcode 000000
        clsVectorAlu,   // opcode 100000
        clsScalarImm,   // opcode 0010xx
        clsLoad,
        clsStore,
        clsVecLoad,
        clsVecStore,
        clsBranchCond,  // beq, bgt
        clsJump,        // b
        clsIllegal
    } instrClassE;

    // encoding matches the function field
    typedef enum logic [2:0] {
        aluAdd = 3'b000,
        aluSub = 3'b001,
        aluAnd = 3'b010,
        aluSll = 3'b011,
        aluOr  = 3'b100,
        aluXor = 3'b101,
        aluSlt = 3'b110,
        aluSrl = 3'b111
    } aluCtrlE;

    typedef enum logic [1:0] {
        brNone,
        brEq,
        brGt,
        brAlways
    } branchKindE;

    typedef enum logic [1:0] {
        lsIdle,     // ready for a request
        lsAck,      // ack high until req drops
        lsWaitLow   // ack low, one cycle before idle
    } linkStateE;

endpackage

// ==== rtl/execRegister.sv ====
/*
 Execute-stage control register. Loads the decoded controls on capture,
 holds them under stall and drops the valid bit when a branch flushes.
*/
module execRegister (
    input  logic               clk,
    input  logic               arstN,
    input  logic               capture,
    input  logic               stall,
    input  logic               pcSrc,
    input  logic               regW,
    input  logic               regWV,
    input  logic               memtoReg,
    input  logic               memW,
    input  logic               memSrc,
    input  logic               aluSrc,
    input  logic               aluOp,
    input  logic               illegal,
    input  logic [1:0]         immSrc,
    input  logic [1:0]         regSrc,
    input  cuPkg::branchKindE  branchKind,
    input  cuPkg::aluCtrlE     aluCtrl,
    output logic               exValid,
    output logic               exRegW,
    output logic               exRegWV,
    output logic               exMemtoReg,
    output logic               exMemW,
    output logic               exMemSrc,
    output logic               exAluSrc,
    output logic               exIllegal,
    output logic [1:0]         exImmSrc,
    output logic [1:0]         exRegSrc,
    output cuPkg::aluCtrlE     exAluCtrl,
    output cuPkg::branchKindE  exBranchKind
);

    logic loadValid;

    assign loadValid = capture && !pcSrc;   // squash behind a taken branch

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exValid   <= 1'b0;
            exRegW    <= 1'b0;
            exRegWV   <= 1'b0;
            exMemW    <= 1'b0;
            exIllegal <= 1'b0;
        end else if (!stall) begin  // stall holds everything
            exValid   <= loadValid;
            exRegW    <= loadValid && regW;
            exRegWV   <= loadValid && regWV;
            exMemW    <= loadValid && memW;
            exIllegal <= loadValid && illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            exMemtoReg   <= memtoReg;
            exMemSrc     <= memSrc;
            exAluSrc     <= aluSrc;
            exImmSrc     <= immSrc;
            exRegSrc     <= regSrc;
            exBranchKind <= branchKind;
            exAluCtrl    <= aluOp ? aluCtrl : cuPkg::aluAdd;    // plain add without aluOp
        end
    end

    // decoder never asks for a register write and a memory write together
    assert property (@(posedge clk) disable iff (!arstN)
        !(exRegW && exMemW));

endmodule

// ==== rtl/fetchLink.sv ====
/*
 Receiver side of the four-phase req/ack link from fetch. Acknowledges one
 request at a time and pulses capture on the edge that takes the instruction.
*/
module fetchLink (
    input  logic clk,
    input  logic arstN,
    input  logic instrReq,
    input  logic stall,
    output logic instrAck,
    output logic capture
);

    cuPkg::linkStateE state;
    cuPkg::linkStateE nextState;

    assign capture  = (state == cuPkg::lsIdle) && instrReq && !stall;
    assign instrAck = (state == cuPkg::lsAck);

    always_comb begin
        nextState = state;
        case (state)
            cuPkg::lsIdle: begin
                if (capture) nextState = cuPkg::lsAck;
            end
            cuPkg::lsAck: begin
                if (!instrReq) nextState = cuPkg::lsWaitLow;    // ack drops here
            end
            cuPkg::lsWaitLow: begin
                nextState = cuPkg::lsIdle;
            end
            default: begin
                nextState = cuPkg::lsIdle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= cuPkg::lsIdle;
        end else begin
            state <= nextState;
        end
    end

    // a capture only comes from idle and is answered on the next edge
    assert property (@(posedge clk) disable iff (!arstN)
        capture |-> (state == cuPkg::lsIdle) ##1 instrAck);

    // ack is gone one edge after the request is seen low
    assert property (@(posedge clk) disable iff (!arstN)
        instrAck && !instrReq |=> !instrAck);

endmodule

// ==== rtl/mainDecoder.sv ====
/*
 Main decoder. Combinationally turns the opcode and function field of the
 instruction word into datapath controls and an instruction class.
*/
`include "cuDefs_defs.svh"

module mainDecoder (
    input  logic [`CU_INSTR_W-1:0] instr,
    output logic                   regW,
    output logic                   regWV,
    output logic                   memtoReg,
    output logic                   memW,
    output logic                   memSrc,
    output logic                   aluSrc,
    output logic                   aluOp,
    output logic                   illegal,
    output logic [1:0]             immSrc,
    output logic [1:0]             regSrc,
    output cuPkg::branchKindE      branchKind,
    output cuPkg::instrClassE      instrClass
);

    logic [`CU_OPC_HI-`CU_OPC_LO:0] opcode;
    logic [`CU_FUNC_W-1:0]          func;

    assign opcode = instr[`CU_OPC_HI:`CU_OPC_LO];
    assign func   = instr[`CU_FUNC_W-1:0];

    always_comb begin
        regW       = 1'b0;
        regWV      = 1'b0;
        memtoReg   = 1'b0;
        memW       = 1'b0;
        memSrc     = 1'b0;
        aluSrc     = 1'b0;
        aluOp      = 1'b0;
        illegal    = 1'b0;
        immSrc     = 2'b00;
        regSrc     = 2'b00;
        branchKind = cuPkg::brNone;
        instrClass = cuPkg::clsIllegal;

        casez (opcode)
            6'b000000: begin
                instrClass = cuPkg::clsScalarAlu;
                regW       = 1'b1;
                aluOp      = 1'b1;
                if (func[1:0] == 2'b11) begin   // sll / srl take a shift amount
                    aluSrc = 1'b1;
                    immSrc = 2'b11;
                end
            end
            6'b100000: begin
                instrClass = cuPkg::clsVectorAlu;
                regWV      = 1'b1;
                memtoReg   = 1'b1;
                aluOp      = 1'b1;
            end
            6'b0010??: begin
                instrClass = cuPkg::clsScalarImm;
                regW       = 1'b1;
                aluOp      = 1'b1;
                aluSrc     = 1'b1;
            end
            6'b011000, 6'b111000: begin
                instrClass = opcode[5] ? cuPkg::clsVecStore : cuPkg::clsStore;
                memW       = 1'b1;
                memSrc     = opcode[5];                 // vector side memory
                aluSrc     = 1'b1;
                regSrc     = 2'b01;                     // store data from rd
            end
            6'b011001: begin
                instrClass = cuPkg::clsLoad;
                regW       = 1'b1;
                memtoReg   = 1'b1;
                aluSrc     = 1'b1;
            end
            6'b111001: begin
                instrClass = cuPkg::clsVecLoad;
                regWV      = 1'b1;
                memtoReg   = 1'b1;
                memSrc     = 1'b1;
                aluSrc     = 1'b1;
            end
            6'b001100, 6'b001101: begin
                instrClass = cuPkg::clsBranchCond;
                branchKind = opcode[0] ? cuPkg::brGt : cuPkg::brEq;
                aluOp      = 1'b1;                      // compare by subtract
                regSrc     = 2'b01;
            end
            6'b000100: begin
                instrClass = cuPkg::clsJump;
                branchKind = cuPkg::brAlways;
            end
            default: begin
                illegal = 1'b1;     // all writes stay off
            end
        endcase
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the control unit testbench with Verilator.
# The simulator's exit status carries pass or fail.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f list.f \
    --top-module controlUnitTb \
    -o controlUnitSim

./obj_dir/controlUnitSim

// ==== testbench/controlUnitTb.sv ====
/*
 Testbench for the decode-side control unit. Sends table rows over the
 four-phase fetch link and checks the execute controls, stall and flush.
*/
module controlUnitTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int modePlain      = 0;  // plain request
    localparam int modeStallReq   = 1;  // stall raised with the request
    localparam int modeHoldBranch = 2;  // stall right after capture
    localparam int modeFlushed    = 3;  // arrives behind a held taken branch

    logic              clk;
    logic              arstN;
    logic              instrReq;
    logic              stall;
    logic              zero;
    logic              negative;
    logic              overflow;
    logic [31:0]       instr;
    logic              instrAck;
    logic              exValid;
    logic              exRegW;
    logic              exRegWV;
    logic              exMemtoReg;
    logic              exMemW;
    logic              exMemSrc;
    logic              exAluSrc;
    logic              exIllegal;
    logic [1:0]        exImmSrc;
    logic [1:0]        exRegSrc;
    cuPkg::aluCtrlE    exAluCtrl;
    cuPkg::branchKindE exBranchKind;
    logic              pcSrc;

    // table columns
    logic [31:0] rowInstr[$];
    logic [2:0]  rowFlags[$];   // {zero, negative, overflow}
    int          rowMode[$];
    logic [6:0]  rowCtl[$];     // {regW, regWV, memtoReg, memW, memSrc, aluSrc, illegal}
    logic [3:0]  rowSel[$];     // {immSrc, regSrc}
    logic [2:0]  rowAlu[$];
    logic [1:0]  rowBr[$];
    logic        rowPc[$];

    logic [31:0] rngState = 32'he3f0d716;
    int          cycleCount = 0;
    int          cycleLimit = 1000;

    controlUnit u_controlUnit (
        .clk          (clk),
        .arstN        (arstN),
        .instrReq     (instrReq),
        .stall        (stall),
        .zero         (zero),
        .negative     (negative),
        .overflow     (overflow),
        .instr        (instr),
        .instrAck     (instrAck),
        .exValid      (exValid),
        .exRegW       (exRegW),
        .exRegWV      (exRegWV),
        .exMemtoReg   (exMemtoReg),
        .exMemW       (exMemW),
        .exMemSrc     (exMemSrc),
        .exAluSrc     (exAluSrc),
        .exIllegal    (exIllegal),
        .exImmSrc     (exImmSrc),
        .exRegSrc     (exRegSrc),
        .exAluCtrl    (exAluCtrl),
        .exBranchKind (exBranchKind),
        .pcSrc        (pcSrc)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Test failed");
            $fatal(1, "timeout, the run did not finish within %0d cycles", cycleLimit);
        end
    end

    function automatic logic [31:0] xorshift32();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    // middle bits are noise, the decoder must ignore them
    function automatic logic [31:0] makeInstr(input logic [5:0] opc, input logic [2:0] func);
        logic [22:0] noise;
        noise = 23'(xorshift32());
        return {opc, noise, func};
    endfunction

    function automatic logic [16:0] exOutputs();
        return {exValid, exRegW, exRegWV, exMemtoReg, exMemW, exMemSrc, exAluSrc,
                exIllegal, exImmSrc, exRegSrc, exAluCtrl, exBranchKind};
    endfunction

    task automatic nextCycle();
        @(posedge clk);
        #2;     // sample, then drive
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail at %0d ns: %s is %0h, expected %0h", $time, name, actual, expected);
            $display("Test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic addRow(input logic [5:0] opc, input logic [2:0] func, input logic [2:0] flags,
                          input int mode, input logic [6:0] ctl, input logic [3:0] sel,
                          input logic [2:0] alu, input logic [1:0] br, input logic pc);
        rowInstr.push_back(makeInstr(opc, func));
        rowFlags.push_back(flags);
        rowMode.push_back(mode);
        rowCtl.push_back(ctl);
        rowSel.push_back(sel);
        rowAlu.push_back(alu);
        rowBr.push_back(br);
        rowPc.push_back(pc);
    endtask

    task automatic buildTable();
        // scalar ALU, shifts take aluSrc and immSrc 11
        addRow(6'b000000, 3'b000, 3'b000, modePlain, 7'b1000000, 4'b0000, 3'b000, 2'b00, 1'b0);
        addRow(6'b000000, 3'b001, 3'b000, modePlain, 7'b1000000, 4'b0000, 3'b001, 2'b00, 1'b0);
        addRow(6'b000000, 3'b011, 3'b000, modePlain, 7'b1000010, 4'b1100, 3'b011, 2'b00, 1'b0);
        addRow(6'b000000, 3'b111, 3'b000, modePlain, 7'b1000010, 4'b1100, 3'b111, 2'b00, 1'b0);
        addRow(6'b000000, 3'b110, 3'b000, modePlain, 7'b1000000, 4'b0000, 3'b110, 2'b00, 1'b0);
        // vector ALU
        addRow(6'b100000, 3'b101, 3'b000, modePlain, 7'b0110000, 4'b0000, 3'b101, 2'b00, 1'b0);
        addRow(6'b100000, 3'b010, 3'b000, modeStallReq, 7'b0110000, 4'b0000, 3'b010, 2'b00, 1'b0);
        // immediates, sub falls back to add
        addRow(6'b001000, 3'b100, 3'b000, modePlain, 7'b1000010, 4'b0000, 3'b100, 2'b00, 1'b0);
        addRow(6'b001011, 3'b001, 3'b000, modePlain, 7'b1000010, 4'b0000, 3'b000, 2'b00, 1'b0);
        addRow(6'b001001, 3'b011, 3'b000, modePlain, 7'b1000010, 4'b0000, 3'b011, 2'b00, 1'b0);
        // memory
        addRow(6'b011000, 3'b101, 3'b000, modePlain, 7'b0001010, 4'b0001, 3'b000, 2'b00, 1'b0);
        addRow(6'b111000, 3'b010, 3'b000, modePlain, 7'b0001110, 4'b0001, 3'b000, 2'b00, 1'b0);
        addRow(6'b011001, 3'b110, 3'b000, modePlain, 7'b1010010, 4'b0000, 3'b000, 2'b00, 1'b0);
        addRow(6'b111001, 3'b011, 3'b000, modePlain, 7'b0110110, 4'b0000, 3'b000, 2'b00, 1'b0);
        addRow(6'b011001, 3'b001, 3'b000, modeStallReq, 7'b1010010, 4'b0000, 3'b000, 2'b00, 1'b0);
        // beq and bgt over flag combinations
        addRow(6'b001100, 3'b000, 3'b100, modePlain, 7'b0000000, 4'b0001, 3'b001, 2'b01, 1'b1);
        addRow(6'b001100, 3'b000, 3'b010, modePlain, 7'b0000000, 4'b0001, 3'b001, 2'b01, 1'b0);
        addRow(6'b001101, 3'b000, 3'b000, modePlain, 7'b0000000, 4'b0001, 3'b001, 2'b10, 1'b1);
        addRow(6'b001101, 3'b000, 3'b011, modePlain, 7'b0000000, 4'b0001, 3'b001, 2'b10, 1'b1);
        addRow(6'b001101, 3'b000, 3'b010, modePlain, 7'b0000000, 4'b0001, 3'b001, 2'b10, 1'b0);
        addRow(6'b001101, 3'b000, 3'b100, modePlain, 7'b0000000, 4'b0001, 3'b001, 2'b10, 1'b0);
        addRow(6'b001101, 3'b000, 3'b001, modePlain, 7'b0000000, 4'b0001, 3'b001, 2'b10, 1'b0);
        addRow(6'b000100, 3'b000, 3'b000, modePlain, 7'b0000000, 4'b0000, 3'b000, 2'b11, 1'b1);
        // unimplemented opcodes
        addRow(6'b011010, 3'b000, 3'b000, modePlain, 7'b0000001, 4'b0000, 3'b000, 2'b00, 1'b0);
        addRow(6'b111111, 3'b101, 3'b000, modePlain, 7'b0000001, 4'b0000, 3'b000, 2'b00, 1'b0);
        // taken b held in execute, next one gets flushed
        addRow(6'b000100, 3'b000, 3'b010, modeHoldBranch, 7'b0000000, 4'b0000, 3'b000, 2'b11, 1'b1);
        addRow(6'b000000, 3'b000, 3'b000, modeFlushed, 7'b1000000, 4'b0000, 3'b000, 2'b00, 1'b0);
        addRow(6'b100000, 3'b100, 3'b000, modePlain, 7'b0110000, 4'b0000, 3'b100, 2'b00, 1'b0);
    endtask

    task automatic checkExec(input int idx);
        checkValue("exValid", 32'(exValid), 32'd1);
        checkValue("exRegW", 32'(exRegW), 32'(rowCtl[idx][6]));
        checkValue("exRegWV", 32'(exRegWV), 32'(rowCtl[idx][5]));
        checkValue("exMemtoReg", 32'(exMemtoReg), 32'(rowCtl[idx][4]));
        checkValue("exMemW", 32'(exMemW), 32'(rowCtl[idx][3]));
        checkValue("exMemSrc", 32'(exMemSrc), 32'(rowCtl[idx][2]));
        checkValue("exAluSrc", 32'(exAluSrc), 32'(rowCtl[idx][1]));
        checkValue("exIllegal", 32'(exIllegal), 32'(rowCtl[idx][0]));
        checkValue("exImmSrc", 32'(exImmSrc), 32'(rowSel[idx][3:2]));
        checkValue("exRegSrc", 32'(exRegSrc), 32'(rowSel[idx][1:0]));
        checkValue("exAluCtrl", 32'(exAluCtrl), 32'(rowAlu[idx]));
        checkValue("exBranchKind", 32'(exBranchKind), 32'(rowBr[idx]));
        checkValue("pcSrc", 32'(pcSrc), 32'(rowPc[idx]));
    endtask

    task automatic runRow(input int idx);
        int          mode;
        int          gap;
        int          holdLen;
        logic [16:0] held;
        mode = rowMode[idx];
        gap = int'(xorshift32() % 4);
        repeat (gap) nextCycle();
        instr = rowInstr[idx];
        {zero, negative, overflow} = rowFlags[idx];
        instrReq = 1'b1;
        if (mode == modeStallReq || mode == modeFlushed) begin
            held = exOutputs();
            stall = 1'b1;
            holdLen = 1 + int'(xorshift32() % 3);
            repeat (holdLen) begin
                nextCycle();
                checkValue("instrAck under stall", 32'(instrAck), 32'd0);
                checkValue("ex outputs under stall", 32'(exOutputs()), 32'(held));
                if (mode == modeFlushed) begin
                    checkValue("pcSrc of held branch", 32'(pcSrc), 32'd1);
                end
            end
            stall = 1'b0;
        end
        nextCycle();
        while (!instrAck) begin
            checkValue("exValid before ack", 32'(exValid), 32'd0);
            nextCycle();
        end
        if (mode == modeFlushed) begin
            checkValue("exValid of flushed instr", 32'(exValid), 32'd0);
            checkValue("pcSrc after flush", 32'(pcSrc), 32'd0);
        end else begin
            checkExec(idx);
        end
        instrReq = 1'b0;
        if (mode == modeHoldBranch) begin
            stall = 1'b1;   // keep the branch in execute
        end
        nextCycle();
        checkValue("instrAck after req low", 32'(instrAck), 32'd0);
        checkValue("exValid one cycle later", 32'(exValid), 32'(mode == modeHoldBranch));
    endtask

    initial begin
        arstN    = 1'b0;
        instrReq = 1'b0;
        stall    = 1'b0;
        zero     = 1'b0;
        negative = 1'b0;
        overflow = 1'b0;
        instr    = '0;
        buildTable();
        cycleLimit = rowInstr.size() * 12 + 40;

        repeat (4) @(posedge clk);
        #2;
        checkValue("instrAck in reset", 32'(instrAck), 32'd0);
        checkValue("exValid in reset", 32'(exValid), 32'd0);
        checkValue("pcSrc in reset", 32'(pcSrc), 32'd0);
        checkValue("ex writes in reset", 32'({exRegW, exRegWV, exMemW}), 32'd0);
        arstN = 1'b1;
        nextCycle();

        for (int i = 0; i < rowInstr.size(); i++) begin
            runRow(i);
        end

        repeat (2) nextCycle();
        $display("Test completed successfully");
        $finish;
    end

endmodule
